/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // 64-bit address and data path
  typedef logic [63:0] dword_t;

  // one enable bit per byte lane
  typedef logic [7:0] byte_mask_t;

  // access width code
  typedef logic [1:0] size_t;

  localparam size_t SIZE_BYTE   = 2'd0;
  localparam size_t SIZE_HALF   = 2'd1;
  localparam size_t SIZE_WORD   = 2'd2;
  localparam size_t SIZE_DOUBLE = 2'd3;

  // byte offset inside a double word, addr[2:0]
  typedef logic [2:0] lane_sel_t;

  // one memory request as issued by the core
  typedef struct packed {
    logic   we;
    size_t  size;
    logic   zext;
    dword_t addr;
    dword_t wdata;
  } mem_req_t;

  // access sequencing
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESP
  } ctrl_state_t;

endpackage

`default_nettype wire

/* lane_steer.sv */
`default_nettype none

module lane_steer (
  input  mem_pkg::mem_req_t   cur_req,
  output mem_pkg::byte_mask_t mask,
  output mem_pkg::dword_t     lane_wdata,
  output logic                misaligned
);

  import mem_pkg::*;

  lane_sel_t  offset;
  byte_mask_t base_mask;
  logic [5:0] bit_shift;

  assign offset    = cur_req.addr[2:0];
  assign bit_shift = {offset, 3'b000};

  // lanes covered by the access when it starts at lane 0
  always_comb begin
    case (cur_req.size)
      SIZE_BYTE:   base_mask = 8'b0000_0001;
      SIZE_HALF:   base_mask = 8'b0000_0011;
      SIZE_WORD:   base_mask = 8'b0000_1111;
      default:     base_mask = 8'b1111_1111;
    endcase
  end

  // move the window up to the addressed lane
  assign mask = base_mask << offset;

  // offset must be a multiple of the access width
  always_comb begin
    case (cur_req.size)
      SIZE_BYTE:   misaligned = 1'b0;
      SIZE_HALF:   misaligned = offset[0];
      SIZE_WORD:   misaligned = |offset[1:0];
      default:     misaligned = |offset;
    endcase
  end

  // store data lines up with its lanes, unused lanes are masked off in the RAM
  assign lane_wdata = cur_req.wdata << bit_shift;

endmodule

`default_nettype wire

/* load_extract.sv */
`default_nettype none

module load_extract (
  input  mem_pkg::mem_req_t cur_req,
  input  mem_pkg::dword_t   ram_rdata,
  output mem_pkg::dword_t   rdata
);

  import mem_pkg::*;

  lane_sel_t  offset;
  logic [5:0] bit_shift;
  dword_t     shifted;
  logic       sign_bit;

  assign offset    = cur_req.addr[2:0];
  assign bit_shift = {offset, 3'b000};

  // addressed lane down to bit 0
  assign shifted = ram_rdata >> bit_shift;

  // top bit of the kept part, forced low for unsigned loads
  always_comb begin
    case (cur_req.size)
      SIZE_BYTE:   sign_bit = shifted[7];
      SIZE_HALF:   sign_bit = shifted[15];
      SIZE_WORD:   sign_bit = shifted[31];
      default:     sign_bit = shifted[63];
    endcase
    if (cur_req.zext) begin
      sign_bit = 1'b0;
    end
  end

  // keep the access width, fill the rest with the extension bit
  always_comb begin
    case (cur_req.size)
      SIZE_BYTE: begin
        rdata = {{56{sign_bit}}, shifted[7:0]};
      end
      SIZE_HALF: begin
        rdata = {{48{sign_bit}}, shifted[15:0]};
      end
      SIZE_WORD: begin
        rdata = {{32{sign_bit}}, shifted[31:0]};
      end
      default: begin
        rdata = shifted;
      end
    endcase
  end

endmodule

`default_nettype wire

/* data_ram.sv */
`default_nettype none

module data_ram #(
  parameter int DEPTH_LOG2 = 8
) (
  input  logic                clk,
  input  logic                en,
  input  logic                we,
  input  mem_pkg::dword_t     addr,
  input  mem_pkg::byte_mask_t mask,
  input  mem_pkg::dword_t     wdata,
  output mem_pkg::dword_t     rdata
);

  import mem_pkg::*;

  dword_t                mem_q [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] word_idx;

  // upper address bits beyond the depth are dropped, so addresses alias
  assign word_idx = addr[DEPTH_LOG2+2:3];

  initial begin
    for (int i = 0; i < 2**DEPTH_LOG2; i++) begin
      mem_q[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        // only the enabled lanes change
        for (int b = 0; b < 8; b++) begin
          if (mask[b]) begin
            mem_q[word_idx][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end else begin
        rdata <= mem_q[word_idx];
      end
    end
  end

endmodule

`default_nettype wire

/* mem_ctrl.sv */
`default_nettype none

module mem_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req,
  input  mem_pkg::mem_req_t req_in,
  input  logic              misaligned,
  output mem_pkg::mem_req_t cur_req,
  output logic              ram_en,
  output logic              ram_we,
  output logic              busy,
  output logic              done,
  output logic              err
);

  import mem_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        accept;

  // new work is taken only from idle, a req while busy is dropped
  assign accept = req && (state_q == ST_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_ACCESS;
        end
      end
      ST_ACCESS: begin
        state_d = ST_RESP;
      end
      ST_RESP: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request held stable for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_req <= req_in;
    end
  end

  // misaligned accesses never reach the RAM
  assign ram_en = (state_q == ST_ACCESS) && !misaligned;
  assign ram_we = (state_q == ST_ACCESS) && cur_req.we;

  assign busy = (state_q != ST_IDLE);

  // one-cycle response, err qualified by done
  assign done = (state_q == ST_RESP);
  assign err  = done && misaligned;

endmodule

`default_nettype wire

/* mem_unit.sv */
`default_nettype none

module mem_unit #(
  parameter int DEPTH_LOG2 = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req,
  input  mem_pkg::mem_req_t req_in,
  output logic              busy,
  output logic              done,
  output logic              err,
  output mem_pkg::dword_t   rdata
);

  import mem_pkg::*;

  mem_req_t   cur_req;
  byte_mask_t mask;
  dword_t     lane_wdata;
  logic       misaligned;
  logic       ram_en;
  logic       ram_we;
  dword_t     ram_rdata;

  // request capture and access sequencing
  mem_ctrl u_mem_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .req_in     (req_in),
    .misaligned (misaligned),
    .cur_req    (cur_req),
    .ram_en     (ram_en),
    .ram_we     (ram_we),
    .busy       (busy),
    .done       (done),
    .err        (err)
  );

  // byte lanes and alignment check for the held request
  lane_steer u_lane_steer (
    .cur_req    (cur_req),
    .mask       (mask),
    .lane_wdata (lane_wdata),
    .misaligned (misaligned)
  );

  data_ram #(
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) u_data_ram (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (cur_req.addr),
    .mask  (mask),
    .wdata (lane_wdata),
    .rdata (ram_rdata)
  );

  // load alignment and sign or zero extension
  load_extract u_load_extract (
    .cur_req   (cur_req),
    .ram_rdata (ram_rdata),
    .rdata     (rdata)
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_mem_unit.sv */
`default_nettype none

module tb_mem_unit;

  import mem_pkg::*;

  localparam int DONE_TIMEOUT  = 20;
  localparam int RESET_TIMEOUT = 32;
  localparam int DONE_LATENCY  = 2;

  // one request and what the unit should answer
  typedef struct packed {
    logic   we;
    size_t  size;
    logic   zext;
    dword_t addr;
    dword_t wdata;
    dword_t exp_rdata;
    logic   exp_err;
    logic   dup_req;
  } stim_row_t;

  logic      clk;
  logic      rst_n;
  logic      req;
  mem_req_t  req_in;
  logic      busy;
  logic      done;
  logic      err;
  dword_t    rdata;
  stim_row_t rows[$];
  int        errors;
  int        checks;
  int        rst_cycles;
  logic      timed_out;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mem_unit #(
    .DEPTH_LOG2 (8)
  ) u_mem_unit (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .req_in (req_in),
    .busy   (busy),
    .done   (done),
    .err    (err),
    .rdata  (rdata)
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_and_finish();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic add_row(input logic we, input size_t size, input logic zext,
                         input dword_t addr, input dword_t wdata, input dword_t exp_rdata,
                         input logic exp_err, input logic dup_req);
    rows.push_back({we, size, zext, addr, wdata, exp_rdata, exp_err, dup_req});
  endtask

  task automatic build_table();
    // double round trip
    add_row(1'b1, SIZE_DOUBLE, 1'b0, 64'h100, 64'h0123_4567_89ab_cdef, 64'h0, 1'b0, 1'b0);
    add_row(1'b0, SIZE_DOUBLE, 1'b0, 64'h100, 64'h0, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0);
    // partial stores into lanes 3, 6 and 7 drop the upper wdata bits
    add_row(1'b1, SIZE_DOUBLE, 1'b0, 64'h200, 64'h1122_3344_5566_7788, 64'h0, 1'b0, 1'b0);
    add_row(1'b1, SIZE_BYTE, 1'b0, 64'h203, 64'hffff_ffff_ffff_ffaa, 64'h0, 1'b0, 1'b0);
    add_row(1'b1, SIZE_HALF, 1'b0, 64'h206, 64'h1234_5678_9abc_beef, 64'h0, 1'b0, 1'b0);
    add_row(1'b0, SIZE_DOUBLE, 1'b0, 64'h200, 64'h0, 64'hbeef_3344_aa66_7788, 1'b0, 1'b0);
    // lanes fe dc ba 98 87 65 43 21 from top to bottom
    add_row(1'b1, SIZE_DOUBLE, 1'b0, 64'h300, 64'hfedc_ba98_8765_4321, 64'h0, 1'b0, 1'b0);
    add_row(1'b0, SIZE_BYTE, 1'b0, 64'h303, 64'h0, 64'hffff_ffff_ffff_ff87, 1'b0, 1'b0);
    add_row(1'b0, SIZE_BYTE, 1'b1, 64'h303, 64'h0, 64'h0000_0000_0000_0087, 1'b0, 1'b0);
    add_row(1'b0, SIZE_HALF, 1'b0, 64'h306, 64'h0, 64'hffff_ffff_ffff_fedc, 1'b0, 1'b0);
    add_row(1'b0, SIZE_HALF, 1'b1, 64'h306, 64'h0, 64'h0000_0000_0000_fedc, 1'b0, 1'b0);
    add_row(1'b0, SIZE_WORD, 1'b0, 64'h304, 64'h0, 64'hffff_ffff_fedc_ba98, 1'b0, 1'b0);
    add_row(1'b0, SIZE_WORD, 1'b1, 64'h304, 64'h0, 64'h0000_0000_fedc_ba98, 1'b0, 1'b0);
    add_row(1'b0, SIZE_BYTE, 1'b0, 64'h300, 64'h0, 64'h0000_0000_0000_0021, 1'b0, 1'b0);
    add_row(1'b0, SIZE_WORD, 1'b0, 64'h300, 64'h0, 64'hffff_ffff_8765_4321, 1'b0, 1'b0);
    // misaligned accesses raise err and leave the memory alone
    add_row(1'b0, SIZE_HALF, 1'b0, 64'h301, 64'h0, 64'h0, 1'b1, 1'b0);
    add_row(1'b1, SIZE_WORD, 1'b0, 64'h302, 64'hdead_beef, 64'h0, 1'b1, 1'b0);
    add_row(1'b0, SIZE_DOUBLE, 1'b0, 64'h304, 64'h0, 64'h0, 1'b1, 1'b0);
    add_row(1'b0, SIZE_DOUBLE, 1'b0, 64'h300, 64'h0, 64'hfedc_ba98_8765_4321, 1'b0, 1'b0);
    // second req during the access is dropped
    add_row(1'b1, SIZE_DOUBLE, 1'b0, 64'h400, 64'h5555_aaaa_1234_5678, 64'h0, 1'b0, 1'b1);
    add_row(1'b0, SIZE_DOUBLE, 1'b0, 64'h400, 64'h0, 64'h5555_aaaa_1234_5678, 1'b0, 1'b0);
    // high address bits alias onto word 0x20
    add_row(1'b0, SIZE_DOUBLE, 1'b0, 64'h8000_0000_0000_0900, 64'h0,
            64'h0123_4567_89ab_cdef, 1'b0, 1'b0);
  endtask

  task automatic run_row(input int idx, input stim_row_t row, output logic no_done);
    mem_req_t new_req;
    mem_req_t dup_req;
    int       cycles;
    logic     got_done;
    new_req.we    = row.we;
    new_req.size  = row.size;
    new_req.zext  = row.zext;
    new_req.addr  = row.addr;
    new_req.wdata = row.wdata;
    // a conflicting store to the same word
    dup_req       = new_req;
    dup_req.we    = 1'b1;
    dup_req.size  = SIZE_DOUBLE;
    dup_req.wdata = ~row.wdata;

    @(posedge clk);
    #1;
    req    = 1'b1;
    req_in = new_req;
    cycles   = 0;
    got_done = 1'b0;
    while (!got_done && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
      check_value($sformatf("busy (row %0d)", idx), busy, 1'b1);
      if (done === 1'b1) begin
        got_done = 1'b1;
      end else if (cycles == 1 && row.dup_req) begin
        req_in = dup_req;
      end else begin
        req = 1'b0;
      end
    end
    req     = 1'b0;
    no_done = !got_done;

    if (!got_done) begin
      errors++;
      $display("row %0d: done did not arrive within %0d cycles", idx, DONE_TIMEOUT);
    end else begin
      check_value($sformatf("done latency (row %0d)", idx), cycles, DONE_LATENCY);
      check_value($sformatf("err (row %0d)", idx), err, row.exp_err);
      if (!row.we && !row.exp_err) begin
        check_value($sformatf("rdata (row %0d)", idx), rdata, row.exp_rdata);
      end

      // done lasts one cycle and a dropped req starts nothing
      repeat (3) begin
        @(posedge clk);
        #1;
        check_value($sformatf("done (row %0d)", idx), done, 1'b0);
        check_value($sformatf("busy (row %0d)", idx), busy, 1'b0);
      end
    end
  endtask

  initial begin
    req        = 1'b0;
    req_in     = '0;
    errors     = 0;
    checks     = 0;
    rst_cycles = 0;
    timed_out  = 1'b0;
    build_table();

    while (rst_n !== 1'b1 && rst_cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      #1;
      rst_cycles++;
      check_value("busy (reset)", busy, 1'b0);
      check_value("done (reset)", done, 1'b0);
      check_value("err (reset)", err, 1'b0);
    end

    if (rst_n !== 1'b1) begin
      errors++;
      $display("reset was not released within %0d cycles", RESET_TIMEOUT);
    end else begin
      repeat (2) begin
        @(posedge clk);
        #1;
        check_value("busy (after reset)", busy, 1'b0);
        check_value("done (after reset)", done, 1'b0);
        check_value("err (after reset)", err, 1'b0);
      end

      foreach (rows[i]) begin
        if (!timed_out) begin
          run_row(i, rows[i], timed_out);
        end
      end
    end

    report_and_finish();
  end

endmodule

`default_nettype wire

/* list.f */
mem_pkg.sv
lane_steer.sv
load_extract.sv
data_ram.sv
mem_ctrl.sv
mem_unit.sv
tb_clk_gen.sv
tb_mem_unit.sv

/* Bender.yml */
package:
  name: mem_unit

sources:
  - mem_pkg.sv
  - lane_steer.sv
  - load_extract.sv
  - data_ram.sv
  - mem_ctrl.sv
  - mem_unit.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_mem_unit.sv
